/* source/lv_mode_pkg.sv */
//====================================================================
// lv mode package
// operating modes of the low-voltage die controller
//====================================================================
package lv_mode_pkg;

    localparam int LV_ST_W = 4;  // mode register width

    //====================================================================
    // operating modes
    //====================================================================
    typedef enum logic [LV_ST_W-1:0] {
        ST_POWER_DOWN   = 4'd0,  // supply off, everything disabled
        ST_WAIT         = 4'd1,  // woken up, efuse load in flight
        ST_TEST         = 4'd2,  // trim and test access
        ST_NORMAL       = 4'd3,  // pwm running
        ST_FAILSAFE     = 4'd4,
        ST_OW_COMM_ERR  = 4'd5,  // one-wire protocol or crc error
        ST_OW_WDG_FAULT = 4'd6,  // one-wire link lost
        ST_FAULT        = 4'd7,  // analog or system fault
        ST_CFG          = 4'd8   // register configuration
    } lv_state_e;

endpackage

/* source/lv_sig_pkg.sv */
//====================================================================
// lv signal package
// command, fault and block-enable bundles of the mode controller
//====================================================================
package lv_sig_pkg;

    // commands from the register block, msb first
    typedef struct packed {
        logic power_on;
        logic test_mode;
        logic efuse_vld;   // efuse data already in registers
        logic efuse_done;
        logic fsenb_n;     // failsafe request, active low
        logic normal_en;
        logic cfg_en;
        logic sft_rst;
    } lv_cmd_t;

    // raw fault flags
    typedef struct packed {
        logic ow_com;      // one-wire protocol or crc error
        logic ow_wdg;      // one-wire ack lost
        logic spi;
        logic crc_wdg;     // config register crc scan failed
        logic lv_pwm_dt;   // dead time
        logic lv_pwm_mm;   // pwm mismatch
        logic lv_vsup_uv;
        logic lv_vsup_ov;
        logic hv_vcc_uv;
        logic hv_vcc_ov;
        logic hv_ot;
        logic hv_oc;
        logic hv_desat;
        logic hv_scp;      // short circuit
    } lv_fault_t;

    // grouped faults seen by the state machine and the decoder
    typedef struct packed {
        logic ow_com;
        logic ow_wdg;
        logic sys_err;
        logic lvhv_any;
        logic lvhv_hard;
        logic all_err;
    } lv_fault_sum_t;

    // registered block enables, int_n active low
    typedef struct packed {
        logic pwm;
        logic crc_wdg;
        logic ow_wdg;
        logic spi;
        logic cfg;
        logic ow_comm;
        logic fsafe;
        logic int_n;
    } lv_ctrl_t;

endpackage

/* source/lv_fault_merge.sv */
//====================================================================
// lv fault merge
// folds the fourteen fault flags into the summary groups
//====================================================================
`timescale 1ns/1ps

module lv_fault_merge (
    input  lv_sig_pkg::lv_fault_t     i_fault,
    output lv_sig_pkg::lv_fault_sum_t o_sum
);

    logic lv_any;   // low-voltage side analog flags
    logic hv_any;   // high-voltage side analog flags
    logic sup_err;  // supply out of range on either side

    assign lv_any  = i_fault.lv_pwm_dt | i_fault.lv_pwm_mm |
                     i_fault.lv_vsup_uv | i_fault.lv_vsup_ov;
    assign hv_any  = i_fault.hv_vcc_uv | i_fault.hv_vcc_ov | i_fault.hv_ot |
                     i_fault.hv_oc | i_fault.hv_desat | i_fault.hv_scp;
    assign sup_err = i_fault.lv_vsup_uv | i_fault.lv_vsup_ov |
                     i_fault.hv_vcc_uv | i_fault.hv_vcc_ov;

    always_comb begin
        o_sum.ow_com    = i_fault.ow_com;
        o_sum.ow_wdg    = i_fault.ow_wdg;
        o_sum.sys_err   = i_fault.spi | i_fault.crc_wdg;
        o_sum.lvhv_any  = lv_any | hv_any;
        // oc and pwm timing errors are left out, failsafe rides those
        o_sum.lvhv_hard = sup_err | i_fault.hv_ot | i_fault.hv_desat | i_fault.hv_scp;
        o_sum.all_err   = i_fault.ow_com | i_fault.ow_wdg | o_sum.sys_err | o_sum.lvhv_any;
    end

endmodule

/* source/lv_boot_seq.sv */
//====================================================================
// lv boot sequencer
// efuse load strobe on wake, sticky load-done lock
//====================================================================
`timescale 1ns/1ps

module lv_boot_seq (
    input  logic i_clk,
    input  logic i_rst_n,
    input  logic i_wake,             // one cycle, power-down to wait
    input  logic i_efuse_vld,        // registers already hold efuse data
    input  logic i_efuse_load_done,  // pulse or level from efuse block
    output logic o_efuse_load_en,
    output logic o_load_done_lock
);

    logic load_req;

    assign load_req = i_wake & ~i_efuse_vld;  // reload only when data missing

    //====================================================================
    // load strobe
    //====================================================================
    always_ff @(posedge i_clk or negedge i_rst_n) begin
        if (!i_rst_n) begin
            o_efuse_load_en <= 1'b0;
        end else begin
            o_efuse_load_en <= load_req;  // single cycle, wake is single cycle
        end
    end

    //====================================================================
    // done lock
    //====================================================================
    // every wake starts a new boot, so it wins over a late done
    always_ff @(posedge i_clk or negedge i_rst_n) begin
        if (!i_rst_n) begin
            o_load_done_lock <= 1'b0;
        end else if (i_wake) begin
            o_load_done_lock <= 1'b0;
        end else if (i_efuse_load_done) begin
            o_load_done_lock <= 1'b1;
        end
    end

endmodule

/* source/lv_mode_fsm.sv */
//====================================================================
// lv mode fsm
// picks the operating mode from commands, fault groups and boot status
//====================================================================
`timescale 1ns/1ps

module lv_mode_fsm (
    input  logic                      i_clk,
    input  logic                      i_rst_n,
    input  lv_sig_pkg::lv_cmd_t       i_cmd,
    input  lv_sig_pkg::lv_fault_sum_t i_sum,
    input  logic                      i_load_done_lock,
    output lv_mode_pkg::lv_state_e    o_state,
    output logic                      o_wake
);

    import lv_mode_pkg::*;

    lv_state_e state_d;
    logic      ow_err;    // any one-wire problem
    logic      fs_req;    // failsafe requested
    logic      boot_test; // efuse loaded but not yet programmed

    assign ow_err    = i_sum.ow_com | i_sum.ow_wdg;
    assign fs_req    = ~i_cmd.fsenb_n;
    assign boot_test = i_load_done_lock & ~i_cmd.efuse_vld & ~i_cmd.efuse_done;

    // leaving power-down, lasts exactly one cycle
    assign o_wake = (o_state == ST_POWER_DOWN) & i_cmd.power_on;

    //====================================================================
    // mode register
    //====================================================================
    always_ff @(posedge i_clk or negedge i_rst_n) begin
        if (!i_rst_n) begin
            o_state <= ST_POWER_DOWN;
        end else begin
            o_state <= state_d;
        end
    end

    //====================================================================
    // next mode
    //====================================================================
    always_comb begin
        state_d = o_state;  // hold unless a condition fires
        if (!i_cmd.power_on) begin
            state_d = ST_POWER_DOWN;  // power loss beats everything
        end else begin
            case (o_state)
                ST_POWER_DOWN: begin
                    state_d = ST_WAIT;
                end
                ST_WAIT: begin
                    if (boot_test || i_cmd.test_mode) begin
                        state_d = ST_TEST;
                    end else if (!ow_err && fs_req) begin
                        state_d = ST_FAILSAFE;
                    end else if (!ow_err && i_cmd.normal_en) begin
                        state_d = ST_NORMAL;
                    end
                end
                ST_TEST: begin
                    if (!i_cmd.test_mode && i_cmd.efuse_vld && i_cmd.efuse_done) begin
                        state_d = ST_WAIT;
                    end
                end
                ST_NORMAL: begin
                    if (i_sum.ow_wdg) begin
                        state_d = ST_OW_WDG_FAULT;
                    end else if (i_sum.ow_com) begin
                        state_d = ST_OW_COMM_ERR;
                    end else if (i_cmd.cfg_en) begin
                        state_d = ST_CFG;
                    end else if (fs_req) begin
                        state_d = ST_FAILSAFE;
                    end else if (i_sum.sys_err || i_sum.lvhv_any) begin
                        state_d = ST_FAULT;
                    end
                end
                ST_FAILSAFE: begin
                    if (ow_err) begin
                        state_d = ST_WAIT;  // link gone, back to boot wait
                    end else if (i_sum.lvhv_hard) begin
                        state_d = ST_FAULT;
                    end else if (!fs_req) begin
                        state_d = ST_NORMAL;
                    end
                end
                ST_OW_COMM_ERR: begin
                    if (i_cmd.sft_rst || !i_sum.ow_com) begin
                        state_d = ST_NORMAL;
                    end
                end
                ST_OW_WDG_FAULT: begin
                    if (i_cmd.sft_rst || !i_sum.ow_wdg) begin
                        state_d = ST_NORMAL;
                    end
                end
                ST_FAULT: begin
                    if (i_cmd.cfg_en) begin
                        state_d = ST_CFG;
                    end else if (!i_sum.lvhv_any && fs_req) begin
                        state_d = ST_FAILSAFE;
                    end
                end
                ST_CFG: begin
                    if (!i_sum.all_err && !i_cmd.cfg_en) begin
                        state_d = fs_req ? ST_FAILSAFE : ST_NORMAL;
                    end
                end
                default: begin
                    state_d = ST_POWER_DOWN;  // unused codes
                end
            endcase
        end
    end

endmodule

/* source/lv_ctrl_decode.sv */
//====================================================================
// lv control decode
// registered block enables and interrupt per operating mode
//====================================================================
`timescale 1ns/1ps

module lv_ctrl_decode (
    input  logic                   i_clk,
    input  logic                   i_rst_n,
    input  lv_mode_pkg::lv_state_e i_state,
    input  logic                   i_all_err,
    output lv_sig_pkg::lv_ctrl_t   o_ctrl
);

    import lv_mode_pkg::*;
    import lv_sig_pkg::*;

    // all blocks off, no interrupt
    localparam lv_ctrl_t CTRL_OFF = '{int_n: 1'b1, default: 1'b0};

    lv_ctrl_t ctrl_d;

    //====================================================================
    // enables per mode
    //====================================================================
    always_comb begin
        ctrl_d         = CTRL_OFF;
        ctrl_d.spi     = 1'b1;  // host access stays up once awake
        ctrl_d.ow_comm = 1'b1;
        case (i_state)
            ST_POWER_DOWN: begin
                ctrl_d = CTRL_OFF;
            end
            ST_WAIT: begin
                ctrl_d.int_n = 1'b0;
            end
            ST_TEST: begin
                ctrl_d.cfg = 1'b1;
            end
            ST_NORMAL: begin
                ctrl_d.pwm     = 1'b1;
                ctrl_d.crc_wdg = 1'b1;
                ctrl_d.ow_wdg  = 1'b1;
            end
            ST_FAILSAFE: begin
                ctrl_d.crc_wdg = 1'b1;
                ctrl_d.ow_wdg  = 1'b1;
                ctrl_d.fsafe   = 1'b1;
            end
            ST_OW_COMM_ERR: begin
                ctrl_d.crc_wdg = 1'b1;
                ctrl_d.ow_wdg  = 1'b1;
                ctrl_d.int_n   = 1'b0;
            end
            ST_OW_WDG_FAULT: begin
                ctrl_d.pwm   = o_ctrl.pwm;  // keep switching as before
                ctrl_d.int_n = 1'b0;
            end
            ST_FAULT: begin
                ctrl_d.pwm     = o_ctrl.pwm;
                ctrl_d.crc_wdg = 1'b1;
                ctrl_d.ow_wdg  = 1'b1;
                ctrl_d.int_n   = 1'b0;
            end
            ST_CFG: begin
                ctrl_d.cfg   = 1'b1;
                ctrl_d.int_n = ~i_all_err;  // flag faults still open
            end
            default: begin
                ctrl_d = CTRL_OFF;
            end
        endcase
    end

    always_ff @(posedge i_clk or negedge i_rst_n) begin
        if (!i_rst_n) begin
            o_ctrl <= CTRL_OFF;
        end else begin
            o_ctrl <= ctrl_d;
        end
    end

endmodule

/* source/lv_ctrl_top.sv */
//====================================================================
// lv controller top
// fault merge and boot sequencer feeding the mode fsm and decoder
//====================================================================
`timescale 1ns/1ps

module lv_ctrl_top (
    input  logic                   i_clk,
    input  logic                   i_rst_n,
    input  lv_sig_pkg::lv_cmd_t    i_cmd,
    input  lv_sig_pkg::lv_fault_t  i_fault,
    input  logic                   i_efuse_load_done,
    output lv_mode_pkg::lv_state_e o_state,
    output lv_sig_pkg::lv_ctrl_t   o_ctrl,
    output logic                   o_efuse_load_en
);

    import lv_sig_pkg::*;

    lv_fault_sum_t fault_sum;
    logic          wake;            // power-down exit
    logic          load_done_lock;

    lv_fault_merge u_fault_merge (
        .i_fault (i_fault),
        .o_sum   (fault_sum)
    );

    lv_boot_seq u_boot_seq (
        .i_clk             (i_clk),
        .i_rst_n           (i_rst_n),
        .i_wake            (wake),
        .i_efuse_vld       (i_cmd.efuse_vld),
        .i_efuse_load_done (i_efuse_load_done),
        .o_efuse_load_en   (o_efuse_load_en),
        .o_load_done_lock  (load_done_lock)
    );

    lv_mode_fsm u_mode_fsm (
        .i_clk            (i_clk),
        .i_rst_n          (i_rst_n),
        .i_cmd            (i_cmd),
        .i_sum            (fault_sum),
        .i_load_done_lock (load_done_lock),
        .o_state          (o_state),
        .o_wake           (wake)
    );

    lv_ctrl_decode u_ctrl_decode (
        .i_clk     (i_clk),
        .i_rst_n   (i_rst_n),
        .i_state   (o_state),
        .i_all_err (fault_sum.all_err),
        .o_ctrl    (o_ctrl)
    );

endmodule

/* dv/lv_ctrl_checks.svh */
//====================================================================
// lv controller checks
// typed compare tasks, stop on first mismatch
//====================================================================
`ifndef LV_CTRL_CHECKS_SVH
`define LV_CTRL_CHECKS_SVH

task automatic stop_with_failure();
    $display("** FAIL **");
    $fatal(1, "simulation stopped at first failure");
endtask

task automatic check_state(input lv_mode_pkg::lv_state_e got,
                           input lv_mode_pkg::lv_state_e exp, input int step);
    if (got !== exp) begin
        $display("ERROR at %0t: step %0d state %s (%0d), expected %s (%0d)",
                 $time, step, got.name(), got, exp.name(), exp);
        stop_with_failure();
    end
endtask

task automatic check_ctrl(input lv_sig_pkg::lv_ctrl_t got,
                          input lv_sig_pkg::lv_ctrl_t exp, input int step);
    if (got !== exp) begin
        $display("ERROR at %0t: step %0d ctrl %02h, expected %02h", $time, step, got, exp);
        stop_with_failure();
    end
endtask

task automatic check_count(input int got, input int exp, input int step);
    if (got != exp) begin
        $display("ERROR at %0t: step %0d load strobes %0d, expected %0d", $time, step, got, exp);
        stop_with_failure();
    end
endtask

`endif

/* dv/lv_ctrl_tb.sv */
//====================================================================
// lv controller testbench
// replays the vector file against the mode controller top
//====================================================================
`timescale 1ns/1ps

module lv_ctrl_tb;

    import lv_mode_pkg::*;
    import lv_sig_pkg::*;

    localparam int CLK_HALF    = 4;   // 8 ns period
    localparam int RST_CYCLES  = 10;
    localparam int RST_TIMEOUT = 20;  // cycles allowed for reset values to show
    localparam int HOLD_CYCLES = 4;   // each vector stays this long
    localparam int NUM_STEPS   = 24;  // data lines in the vector file

    localparam lv_ctrl_t RST_CTRL = 8'h01;  // every enable off, int_n high

    logic      i_clk;
    logic      i_rst_n;
    lv_cmd_t   i_cmd;
    lv_fault_t i_fault;
    logic      i_efuse_load_done;
    lv_state_e o_state;
    lv_ctrl_t  o_ctrl;
    logic      o_efuse_load_en;

    int step_no;

    `include "lv_ctrl_checks.svh"

    lv_ctrl_top dut (
        .i_clk             (i_clk),
        .i_rst_n           (i_rst_n),
        .i_cmd             (i_cmd),
        .i_fault           (i_fault),
        .i_efuse_load_done (i_efuse_load_done),
        .o_state           (o_state),
        .o_ctrl            (o_ctrl),
        .o_efuse_load_en   (o_efuse_load_en)
    );

    always #CLK_HALF i_clk = ~i_clk;

    // comment and blank lines carry no vector
    function automatic bit is_data_line(input string line);
        byte first;
        if (line.len() == 0) begin
            return 1'b0;
        end
        first = line.getc(0);
        return (first != "#") && (first != 8'h0a) && (first != 8'h0d);
    endfunction

    //====================================================================
    // one vector driven, held and compared with strobes counted
    //====================================================================
    task automatic run_step(input lv_cmd_t cmd, input lv_fault_t fault,
                            input logic load_done, input lv_state_e exp_state,
                            input lv_ctrl_t exp_ctrl, input int exp_loads);
        int loads;
        int cyc;
        loads = 0;
        @(posedge i_clk);
        #1;
        i_cmd             = cmd;
        i_fault           = fault;
        i_efuse_load_done = load_done;
        for (cyc = 0; cyc < HOLD_CYCLES; cyc++) begin
            @(negedge i_clk);  // registered outputs are stable here
            if (o_efuse_load_en === 1'b1) begin
                loads++;
            end
        end
        check_state(o_state, exp_state, step_no);
        check_ctrl(o_ctrl, exp_ctrl, step_no);
        check_count(loads, exp_loads, step_no);
    endtask

    //====================================================================
    // main sequence
    //====================================================================
    initial begin
        int          fd;
        int          fields;
        int          line_no;
        int          wait_cycles;
        string       line;
        logic [7:0]  cmd_v;
        logic [13:0] fault_v;
        logic        ld_v;
        logic [3:0]  state_v;
        logic [7:0]  ctrl_v;
        int          loads_v;

        $timeformat(-9, 0, " ns", 0);
        i_clk             = 1'b0;
        i_rst_n           = 1'b0;
        i_cmd             = '0;
        i_fault           = '0;
        i_efuse_load_done = 1'b0;
        step_no           = 0;
        line_no           = 0;

        repeat (RST_CYCLES) @(posedge i_clk);
        #1;

        // outputs must sit at their reset values while reset is held
        wait_cycles = 0;
        while (!(o_state === ST_POWER_DOWN && o_ctrl === RST_CTRL &&
                 o_efuse_load_en === 1'b0)) begin
            if (wait_cycles >= RST_TIMEOUT) begin
                $display("DUT outputs did not reach their reset values during reset");
                stop_with_failure();
            end
            @(posedge i_clk);
            #1;
            wait_cycles++;
        end
        i_rst_n = 1'b1;

        fd = $fopen("dv/lv_ctrl_vectors.txt", "r");
        if (fd == 0) begin
            $display("cannot open the vector file dv/lv_ctrl_vectors.txt");
            stop_with_failure();
        end

        while ($fgets(line, fd) != 0) begin
            line_no++;
            if (is_data_line(line)) begin
                fields = $sscanf(line, "%h %h %h %h %h %d",
                                 cmd_v, fault_v, ld_v, state_v, ctrl_v, loads_v);
                if (fields != 6) begin
                    $display("vector file line %0d has %0d of 6 fields", line_no, fields);
                    stop_with_failure();
                end
                step_no++;
                run_step(lv_cmd_t'(cmd_v), lv_fault_t'(fault_v), ld_v,
                         lv_state_e'(state_v), lv_ctrl_t'(ctrl_v), loads_v);
            end
        end
        $fclose(fd);

        if (step_no != NUM_STEPS) begin
            $display("vector file ended after %0d steps, %0d expected", step_no, NUM_STEPS);
            stop_with_failure();
        end else begin
            $display("** PASS **");
            $finish;
        end
    end

endmodule

/* dv/lv_ctrl_vectors.txt */
# columns: cmd fault load_done exp_state exp_ctrl exp_loads (hex, loads decimal)
# cmd msb first: power_on test_mode efuse_vld efuse_done fsenb_n normal_en cfg_en sft_rst
# ctrl msb first: pwm crc_wdg ow_wdg spi cfg ow_comm fsafe int_n
00 0000 0 0 01 0
88 0000 0 1 14 1
88 0000 1 2 1D 0
B8 0000 0 1 14 0
BC 0000 0 3 F5 0
BC 1000 0 6 94 0
BD 0000 0 3 F5 0
BC 2000 0 5 74 0
BC 0000 0 3 F5 0
BC 0200 0 7 F4 0
B4 0000 0 4 77 0
B4 0008 0 7 74 0
B6 0008 0 8 1C 0
BC 0000 0 3 F5 0
3C 0000 0 0 01 0
BC 0000 0 3 F5 0
B4 0000 0 4 77 0
34 0000 0 0 01 0
C8 0000 0 2 1D 1
48 0000 0 0 01 0
BC 0000 0 3 F5 0
BE 0000 0 8 1D 0
BE 0800 0 8 1C 0
3E 0800 0 0 01 0

/* list.f */
+incdir+dv
source/lv_mode_pkg.sv
source/lv_sig_pkg.sv
source/lv_fault_merge.sv
source/lv_boot_seq.sv
source/lv_mode_fsm.sv
source/lv_ctrl_decode.sv
source/lv_ctrl_top.sv
dv/lv_ctrl_tb.sv

/* run_sim.sh */
#!/bin/sh
# build and run the lv controller testbench with verilator
set -e
cd "$(dirname "$0")"
rm -rf obj_dir
verilator --binary --timing --timescale 1ns/1ps -f list.f --top-module lv_ctrl_tb -o lv_ctrl_sim
./obj_dir/lv_ctrl_sim > sim.log 2>&1 || true
cat sim.log
if grep -qxF '** PASS **' sim.log; then
    echo "simulation passed"
else
    echo "simulation failed"
    exit 1
fi
